// ==== src/tpl_adc_consts.svh ====
// Link description is fixed at build time (M=2 L=1 S=1 F=4), one JESD profile only
`ifndef TPL_ADC_CONSTS_SVH
`define TPL_ADC_CONSTS_SVH

// Datapath sizes
`define TPL_NUM_CHANNELS   2
`define TPL_SAMPLE_WIDTH   16
`define TPL_CONV_RES       14
`define TPL_LINK_WIDTH     32
`define TPL_PN_LOCK_COUNT  8

// Link parameters reported through the descriptor registers
`define TPL_JESD_M   8'd2
`define TPL_JESD_L   8'd1
`define TPL_JESD_S   8'd1
`define TPL_JESD_F   8'd4
`define TPL_JESD_N   8'd14
`define TPL_JESD_NP  8'd16

// Register map
`define TPL_ADDR_WIDTH     8
`define TPL_REG_VERSION    8'h00
`define TPL_REG_ID         8'h01
`define TPL_REG_SCRATCH    8'h02
`define TPL_REG_STATUS     8'h03
`define TPL_REG_OVF        8'h04
`define TPL_REG_DESC0      8'h08
`define TPL_REG_DESC1      8'h09
`define TPL_REG_CHAN_BASE  8'h10

`define TPL_CTRL_RESET     8'h07
`define TPL_VERSION        32'h0001_0061
`define TPL_CORE_ID        32'h0000_00a2

`endif

// ==== src/tpl_adc_pkg.sv ====
// Only PN7 and PN15 are implemented; unknown selector codes behave as PN7
package tpl_adc_pkg;

  // ************************************************************
  // PN sequence selection, 4-bit field of the channel CTRL word
  // ************************************************************

  typedef enum logic [3:0] {
    PN_SEQ_PN7  = 4'd0,
    PN_SEQ_PN15 = 4'd1
  } pn_seq_e;

  // ************************************************************
  // PN monitor sync state
  // ************************************************************

  // Out of sync is the reset state, pn_oos reads high there
  typedef enum logic {
    PN_OOS  = 1'b0,
    PN_SYNC = 1'b1
  } pn_state_e;

  // Bit positions inside the channel CTRL register
  typedef enum int {
    CTRL_ENABLE      = 0,
    CTRL_DFMT_ENABLE = 1,
    CTRL_DFMT_SE     = 2,
    CTRL_DFMT_TYPE   = 3
  } ctrl_bit_e;

endpackage

// ==== src/tpl_adc_deframer.sv ====
// Fixed frame layout F=4 S=1 M=2 on one lane; each sample arrives MSB octet first
`include "tpl_adc_consts.svh"

module tpl_adc_deframer (
  input  logic                         link_clk,
  input  logic                         adc_rst,
  input  logic [`TPL_LINK_WIDTH-1:0]   link_data,
  input  logic                         link_valid,
  output logic [`TPL_LINK_WIDTH-1:0]   sample_data,
  output logic                         sample_valid
);

  localparam int NCH = `TPL_NUM_CHANNELS;
  localparam int SW  = `TPL_SAMPLE_WIDTH;

  logic [`TPL_LINK_WIDTH-1:0] frame_swapped;

  // ************************************************************
  // Octet reorder
  // ************************************************************

  // Lane carries the high octet of every sample in the lower byte lane
  genvar c;
  generate
    for (c = 0; c < NCH; c++) begin : g_chan
      assign frame_swapped[c*SW+8 +: 8] = link_data[c*SW   +: 8];
      assign frame_swapped[c*SW   +: 8] = link_data[c*SW+8 +: 8];
    end
  endgenerate

  // ************************************************************
  // Output register
  // ************************************************************

  always_ff @(posedge link_clk) begin
    if (link_valid) begin
      sample_data <= frame_swapped;
    end
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      sample_valid <= 1'b0;
    end else begin
      sample_valid <= link_valid;
    end
  end

endmodule

// ==== src/tpl_adc_pn_monitor.sv ====
// Self-seeded PN check; the first sample after reset or a PN change only seeds
`include "tpl_adc_consts.svh"

module tpl_adc_pn_monitor (
  input  logic                           link_clk,
  input  logic                           adc_rst,
  input  logic [`TPL_SAMPLE_WIDTH-1:0]   sample,
  input  logic                           sample_valid,
  input  tpl_adc_pkg::pn_seq_e           pn_sel,
  output logic                           pn_err,
  output logic                           pn_oos
);

  localparam int CNT_W = $clog2(`TPL_PN_LOCK_COUNT);

  tpl_adc_pkg::pn_state_e       state;
  tpl_adc_pkg::pn_seq_e         pn_sel_q;
  logic [CNT_W-1:0]             run_cnt;
  logic [`TPL_SAMPLE_WIDTH-1:0] prev_sample;
  logic                         prev_vld;
  logic                         sel_change;
  logic                         match;

  // Advance 16 steps from the previous sample, serial output fills MSB first.
  // PN7 lives in the low 7 state bits, taps 7 and 6; PN15 uses taps 15 and 14
  function automatic logic [15:0] pn_advance(input logic [15:0] seed, input logic is_pn15);
    logic [14:0] st;
    logic        fb;
    logic [15:0] res;
    st  = seed[14:0];
    res = '0;
    for (int i = 0; i < 16; i++) begin
      if (is_pn15) begin
        fb = st[14] ^ st[13];
      end else begin
        fb = st[6] ^ st[5];
      end
      res = {res[14:0], fb};
      st  = {st[13:0], fb};
    end
    return res;
  endfunction

  assign sel_change = (pn_sel != pn_sel_q);
  assign match      = (sample == pn_advance(prev_sample, pn_sel == tpl_adc_pkg::PN_SEQ_PN15));
  assign pn_oos     = (state == tpl_adc_pkg::PN_OOS);

  always_ff @(posedge link_clk) begin
    if (sample_valid) begin
      prev_sample <= sample;
    end
  end

  // ************************************************************
  // Sync FSM with run counter
  // ************************************************************

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      state    <= tpl_adc_pkg::PN_OOS;
      pn_sel_q <= tpl_adc_pkg::PN_SEQ_PN7;
      run_cnt  <= '0;
      prev_vld <= 1'b0;
      pn_err   <= 1'b0;
    end else begin
      pn_err <= 1'b0;
      if (sel_change) begin
        // Start over and reseed on a new sequence
        pn_sel_q <= pn_sel;
        state    <= tpl_adc_pkg::PN_OOS;
        run_cnt  <= '0;
        prev_vld <= sample_valid;
      end else if (sample_valid) begin
        prev_vld <= 1'b1;
        if (prev_vld) begin
          pn_err <= (state == tpl_adc_pkg::PN_SYNC) && !match;
          // Count matches while out of sync, mismatches while in sync
          if (match == (state == tpl_adc_pkg::PN_OOS)) begin
            if (run_cnt == CNT_W'(`TPL_PN_LOCK_COUNT - 1)) begin
              state   <= (state == tpl_adc_pkg::PN_OOS) ? tpl_adc_pkg::PN_SYNC
                                                        : tpl_adc_pkg::PN_OOS;
              run_cnt <= '0;
            end else begin
              run_cnt <= run_cnt + 1'b1;
            end
          end else begin
            run_cnt <= '0;
          end
        end
      end
    end
  end

endmodule

// ==== src/tpl_adc_data_format.sv ====
// Assumes 14-bit converter data right aligned in 16 bits; data is only valid with valid high
`include "tpl_adc_consts.svh"

module tpl_adc_data_format (
  input  logic                           link_clk,
  input  logic                           adc_rst,
  input  logic [`TPL_SAMPLE_WIDTH-1:0]   sample,
  input  logic                           sample_valid,
  input  logic                           enable,
  input  logic                           dfmt_enable,
  input  logic                           dfmt_sign_extend,
  input  logic                           dfmt_type,
  output logic [`TPL_SAMPLE_WIDTH-1:0]   data,
  output logic                           valid
);

  localparam int MSB = `TPL_CONV_RES - 1;
  localparam int EXT = `TPL_SAMPLE_WIDTH - `TPL_CONV_RES;

  logic                         conv_msb;
  logic [EXT-1:0]               ext_bits;
  logic [`TPL_SAMPLE_WIDTH-1:0] fmt_data;

  // Offset binary to two's complement is a flip of the converter MSB
  assign conv_msb = sample[MSB] ^ dfmt_type;
  assign ext_bits = dfmt_sign_extend ? {EXT{conv_msb}} : '0;
  assign fmt_data = dfmt_enable ? {ext_bits, conv_msb, sample[MSB-1:0]} : sample;

  // ************************************************************
  // Output register
  // ************************************************************

  always_ff @(posedge link_clk) begin
    if (!enable) begin
      data <= '0;
    end else if (sample_valid) begin
      data <= fmt_data;
    end
  end

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      valid <= 1'b0;
    end else begin
      valid <= sample_valid & enable;
    end
  end

endmodule

// ==== src/tpl_adc_regmap.sv ====
// Single clock domain; one outstanding bus request at a time, acks one cycle after request
`include "tpl_adc_consts.svh"

module tpl_adc_regmap (
  input  logic                         link_clk,
  input  logic                         adc_rst,
  input  logic                         up_wreq,
  input  logic [`TPL_ADDR_WIDTH-1:0]   up_waddr,
  input  logic [31:0]                  up_wdata,
  output logic                         up_wack,
  input  logic                         up_rreq,
  input  logic [`TPL_ADDR_WIDTH-1:0]   up_raddr,
  output logic [31:0]                  up_rdata,
  output logic                         up_rack,
  input  logic                         adc_dovf,
  input  logic [`TPL_NUM_CHANNELS-1:0] pn_err,
  input  logic [`TPL_NUM_CHANNELS-1:0] pn_oos,
  output logic [`TPL_NUM_CHANNELS-1:0] enable,
  output logic [`TPL_NUM_CHANNELS-1:0] dfmt_enable,
  output logic [`TPL_NUM_CHANNELS-1:0] dfmt_sign_extend,
  output logic [`TPL_NUM_CHANNELS-1:0] dfmt_type,
  output tpl_adc_pkg::pn_seq_e         pn_sel [0:`TPL_NUM_CHANNELS-1]
);

  localparam int NCH = `TPL_NUM_CHANNELS;
  localparam int AW  = `TPL_ADDR_WIDTH;

  logic [31:0]    scratch;
  logic           link_status;
  logic           ovf_flag;
  logic [7:0]     ctrl [0:NCH-1];
  logic [NCH-1:0] pn_err_flag;
  logic [31:0]    rd_data;

  // Channel c register at base + 4c + offset
  function automatic logic [AW-1:0] chan_addr(input int c, input int offset);
    return AW'(`TPL_REG_CHAN_BASE + 4 * c + offset);
  endfunction

  // ************************************************************
  // Write side and sticky status
  // ************************************************************

  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_wack     <= 1'b0;
      scratch     <= '0;
      link_status <= 1'b0;
      ovf_flag    <= 1'b0;
      pn_err_flag <= '0;
      for (int c = 0; c < NCH; c++) begin
        ctrl[c] <= `TPL_CTRL_RESET;
      end
    end else begin
      up_wack     <= up_wreq;
      link_status <= 1'b1;
      if (up_wreq && up_waddr == `TPL_REG_SCRATCH) begin
        scratch <= up_wdata;
      end
      // Set beats a clear in the same cycle
      if (adc_dovf) begin
        ovf_flag <= 1'b1;
      end else if (up_wreq && up_waddr == `TPL_REG_OVF && up_wdata[0]) begin
        ovf_flag <= 1'b0;
      end
      for (int c = 0; c < NCH; c++) begin
        if (up_wreq && up_waddr == chan_addr(c, 0)) begin
          ctrl[c] <= up_wdata[7:0];
        end
        if (pn_err[c]) begin
          pn_err_flag[c] <= 1'b1;
        end else if (up_wreq && up_waddr == chan_addr(c, 1) && up_wdata[0]) begin
          pn_err_flag[c] <= 1'b0;
        end
      end
    end
  end

  // ************************************************************
  // Read mux
  // ************************************************************

  always_comb begin
    rd_data = '0;
    case (up_raddr)
      `TPL_REG_VERSION: rd_data = `TPL_VERSION;
      `TPL_REG_ID:      rd_data = `TPL_CORE_ID;
      `TPL_REG_SCRATCH: rd_data = scratch;
      `TPL_REG_STATUS:  rd_data = {29'd0, |pn_err_flag, |pn_oos, link_status};
      `TPL_REG_OVF:     rd_data = {31'd0, ovf_flag};
      `TPL_REG_DESC0:   rd_data = {`TPL_JESD_F, `TPL_JESD_S, `TPL_JESD_L, `TPL_JESD_M};
      `TPL_REG_DESC1:   rd_data = {16'd0, `TPL_JESD_NP, `TPL_JESD_N};
      default:          rd_data = '0;
    endcase
    for (int c = 0; c < NCH; c++) begin
      if (up_raddr == chan_addr(c, 0)) begin
        rd_data = {24'd0, ctrl[c]};
      end
      if (up_raddr == chan_addr(c, 1)) begin
        rd_data = {30'd0, pn_oos[c], pn_err_flag[c]};
      end
    end
  end

  // Read data is zero outside the ack cycle
  always_ff @(posedge link_clk) begin
    if (adc_rst) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= up_rreq;
      up_rdata <= up_rreq ? rd_data : '0;
    end
  end

  // Control fields out of the CTRL words
  genvar g;
  generate
    for (g = 0; g < NCH; g++) begin : g_ctrl
      assign enable[g]           = ctrl[g][tpl_adc_pkg::CTRL_ENABLE];
      assign dfmt_enable[g]      = ctrl[g][tpl_adc_pkg::CTRL_DFMT_ENABLE];
      assign dfmt_sign_extend[g] = ctrl[g][tpl_adc_pkg::CTRL_DFMT_SE];
      assign dfmt_type[g]        = ctrl[g][tpl_adc_pkg::CTRL_DFMT_TYPE];
      assign pn_sel[g]           = tpl_adc_pkg::pn_seq_e'(ctrl[g][7:4]);
    end
  endgenerate

endmodule

// ==== src/tpl_adc_core.sv ====
// Receive transport layer top; no back-pressure, 2 cycles from link_valid to adc_valid
`include "tpl_adc_consts.svh"

module tpl_adc_core (
  input  logic                                           link_clk,
  input  logic                                           adc_rst,
  input  logic [`TPL_LINK_WIDTH-1:0]                     link_data,
  input  logic                                           link_valid,
  input  logic                                           adc_dovf,
  output logic [`TPL_NUM_CHANNELS*`TPL_SAMPLE_WIDTH-1:0] adc_data,
  output logic [`TPL_NUM_CHANNELS-1:0]                   adc_valid,
  input  logic                                           up_wreq,
  input  logic [`TPL_ADDR_WIDTH-1:0]                     up_waddr,
  input  logic [31:0]                                    up_wdata,
  output logic                                           up_wack,
  input  logic                                           up_rreq,
  input  logic [`TPL_ADDR_WIDTH-1:0]                     up_raddr,
  output logic [31:0]                                    up_rdata,
  output logic                                           up_rack
);

  localparam int NCH = `TPL_NUM_CHANNELS;
  localparam int SW  = `TPL_SAMPLE_WIDTH;

  logic [`TPL_LINK_WIDTH-1:0] sample_data;
  logic                       sample_valid;
  logic [NCH-1:0]             pn_err;
  logic [NCH-1:0]             pn_oos;
  logic [NCH-1:0]             enable;
  logic [NCH-1:0]             dfmt_enable;
  logic [NCH-1:0]             dfmt_sign_extend;
  logic [NCH-1:0]             dfmt_type;
  tpl_adc_pkg::pn_seq_e       pn_sel [0:NCH-1];

  tpl_adc_deframer i_deframer (
    .link_clk     (link_clk),
    .adc_rst      (adc_rst),
    .link_data    (link_data),
    .link_valid   (link_valid),
    .sample_data  (sample_data),
    .sample_valid (sample_valid)
  );

  // ************************************************************
  // Per-channel PN check and formatting
  // ************************************************************

  genvar i;
  generate
    for (i = 0; i < NCH; i++) begin : g_channel
      tpl_adc_pn_monitor i_pn_monitor (
        .link_clk     (link_clk),
        .adc_rst      (adc_rst),
        .sample       (sample_data[i*SW +: SW]),
        .sample_valid (sample_valid),
        .pn_sel       (pn_sel[i]),
        .pn_err       (pn_err[i]),
        .pn_oos       (pn_oos[i])
      );

      tpl_adc_data_format i_data_format (
        .link_clk         (link_clk),
        .adc_rst          (adc_rst),
        .sample           (sample_data[i*SW +: SW]),
        .sample_valid     (sample_valid),
        .enable           (enable[i]),
        .dfmt_enable      (dfmt_enable[i]),
        .dfmt_sign_extend (dfmt_sign_extend[i]),
        .dfmt_type        (dfmt_type[i]),
        .data             (adc_data[i*SW +: SW]),
        .valid            (adc_valid[i])
      );
    end
  endgenerate

  tpl_adc_regmap i_regmap (
    .link_clk         (link_clk),
    .adc_rst          (adc_rst),
    .up_wreq          (up_wreq),
    .up_waddr         (up_waddr),
    .up_wdata         (up_wdata),
    .up_wack          (up_wack),
    .up_rreq          (up_rreq),
    .up_raddr         (up_raddr),
    .up_rdata         (up_rdata),
    .up_rack          (up_rack),
    .adc_dovf         (adc_dovf),
    .pn_err           (pn_err),
    .pn_oos           (pn_oos),
    .enable           (enable),
    .dfmt_enable      (dfmt_enable),
    .dfmt_sign_extend (dfmt_sign_extend),
    .dfmt_type        (dfmt_type),
    .pn_sel           (pn_sel)
  );

endmodule

// ==== tb/tb_tpl_adc.sv ====
// Run from the project root; tb/tpl_adc_vectors.txt holds four hex words per operation
module tb_tpl_adc;

  localparam int MAX_OPS = 128;

  logic        link_clk;
  logic        adc_rst;
  logic [31:0] link_data;
  logic        link_valid;
  logic        adc_dovf;
  logic [31:0] adc_data;
  logic [1:0]  adc_valid;
  logic        up_wreq;
  logic [7:0]  up_waddr;
  logic [31:0] up_wdata;
  logic        up_wack;
  logic        up_rreq;
  logic [7:0]  up_raddr;
  logic [31:0] up_rdata;
  logic        up_rack;

  logic [31:0] vec [0:4*MAX_OPS-1];
  int          num_ops;
  int          cyc_limit;
  int          cyc = 0;
  int          neg_cyc = 0;
  integer      seed;
  logic [15:0] pn_cur [0:1];

  // Expected beat results, popped when due
  int          due_q [$];
  logic [31:0] data_q [$];
  logic [1:0]  valid_q [$];

  tpl_adc_core dut (
    .link_clk   (link_clk),
    .adc_rst    (adc_rst),
    .link_data  (link_data),
    .link_valid (link_valid),
    .adc_dovf   (adc_dovf),
    .adc_data   (adc_data),
    .adc_valid  (adc_valid),
    .up_wreq    (up_wreq),
    .up_waddr   (up_waddr),
    .up_wdata   (up_wdata),
    .up_wack    (up_wack),
    .up_rreq    (up_rreq),
    .up_raddr   (up_raddr),
    .up_rdata   (up_rdata),
    .up_rack    (up_rack)
  );

  always #50 link_clk = ~link_clk;

  // ************************************************************
  // Failure reporting
  // ************************************************************

  task automatic end_failed();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic fail_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    $display("Fail at %0t: %s expected %h got %h", $time, name, exp, act);
    end_failed();
  endtask

  // ************************************************************
  // Stimulus reference
  // ************************************************************

  // Polynomial x^n + x^(n-1) + 1, 16 serial bits per sample, MSB first
  function automatic logic [15:0] pn_next_sample(input logic [15:0] prev, input int order);
    logic [14:0] lfsr;
    logic [15:0] out;
    logic        bit_in;
    lfsr = prev[14:0];
    out  = 16'd0;
    for (int i = 0; i < 16; i++) begin
      bit_in = lfsr[order-1] ^ lfsr[order-2];
      out    = {out[14:0], bit_in};
      lfsr   = {lfsr[13:0], bit_in};
    end
    return out;
  endfunction

  // High octet goes first on the lane
  function automatic logic [15:0] swap_octets(input logic [15:0] s);
    return {s[7:0], s[15:8]};
  endfunction

  // ************************************************************
  // Bus and lane operations
  // ************************************************************

  task automatic start_cycle();
    @(posedge link_clk);
    link_valid <= 1'b0;
    up_wreq    <= 1'b0;
    up_rreq    <= 1'b0;
    adc_dovf   <= 1'b0;
  endtask

  task automatic wait_idle(input int n);
    repeat (n) start_cycle();
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    start_cycle();
    up_wreq  <= 1'b1;
    up_waddr <= addr;
    up_wdata <= data;
    start_cycle();
    @(negedge link_clk);
    assert (up_wack === 1'b1) else fail_value("up_wack", 32'd1, {31'd0, up_wack});
  endtask

  task automatic read_compare(input logic [7:0] addr, input logic [31:0] exp);
    start_cycle();
    up_rreq  <= 1'b1;
    up_raddr <= addr;
    start_cycle();
    @(negedge link_clk);
    assert (up_rack === 1'b1) else fail_value("up_rack", 32'd1, {31'd0, up_rack});
    assert (up_rdata === exp) else fail_value("up_rdata", exp, up_rdata);
  endtask

  // Result shows up after the second edge following the issue edge
  task automatic send_beat(input logic [31:0] lane, input logic [31:0] exp_data,
                           input logic [1:0] exp_valid);
    start_cycle();
    link_valid <= 1'b1;
    link_data  <= lane;
    due_q.push_back(neg_cyc + 3);
    data_q.push_back(exp_data);
    valid_q.push_back(exp_valid);
  endtask

  // Channel 0 runs PN7, channel 1 PN15; corrupt flips bit 0 of the sent sample
  task automatic send_pn_stream(input int beats, input logic [1:0] corrupt);
    logic [15:0] s0;
    logic [15:0] s1;
    for (int n = 0; n < beats; n++) begin
      s0 = pn_cur[0] ^ {15'd0, corrupt[0]};
      s1 = pn_cur[1] ^ {15'd0, corrupt[1]};
      start_cycle();
      link_valid <= 1'b1;
      link_data  <= {swap_octets(s1), swap_octets(s0)};
      pn_cur[0] = pn_next_sample(pn_cur[0], 7);
      pn_cur[1] = pn_next_sample(pn_cur[1], 15);
    end
  endtask

  task automatic pulse_dovf();
    start_cycle();
    adc_dovf <= 1'b1;
  endtask

  // ************************************************************
  // Output checker and timeout
  // ************************************************************

  always @(negedge link_clk) begin
    neg_cyc = neg_cyc + 1;
    if (due_q.size() > 0 && due_q[0] == neg_cyc) begin
      assert (adc_valid === valid_q[0])
        else fail_value("adc_valid", {30'd0, valid_q[0]}, {30'd0, adc_valid});
      assert (adc_data === data_q[0]) else fail_value("adc_data", data_q[0], adc_data);
      void'(due_q.pop_front());
      void'(data_q.pop_front());
      void'(valid_q.pop_front());
    end
  end

  always @(posedge link_clk) begin
    cyc = cyc + 1;
    if (cyc > cyc_limit) begin
      $display("Timeout, run went past %0d cycles", cyc_limit);
      end_failed();
    end
  end

  initial begin
    logic [31:0] rnd;
    link_clk   = 1'b0;
    adc_rst    = 1'b1;
    link_data  = 32'd0;
    link_valid = 1'b0;
    adc_dovf   = 1'b0;
    up_wreq    = 1'b0;
    up_waddr   = 8'd0;
    up_wdata   = 32'd0;
    up_rreq    = 1'b0;
    up_raddr   = 8'd0;
    seed       = 32'hb86c;
    $readmemh("tb/tpl_adc_vectors.txt", vec);
    num_ops = 0;
    while (num_ops < MAX_OPS && vec[4*num_ops] != 32'hf) begin
      num_ops++;
    end
    cyc_limit = 4 * num_ops + 200;
    rnd = $random(seed);
    pn_cur[0] = rnd[15:0];
    rnd = $random(seed);
    pn_cur[1] = rnd[15:0];
    repeat (16) @(posedge link_clk);
    adc_rst <= 1'b0;
    for (int i = 0; i < num_ops; i++) begin
      case (vec[4*i])
        32'h0: wait_idle(vec[4*i+1]);
        32'h1: write_reg(vec[4*i+1][7:0], vec[4*i+2]);
        32'h2: read_compare(vec[4*i+1][7:0], vec[4*i+2]);
        32'h3: send_beat(vec[4*i+1], vec[4*i+2], vec[4*i+3][1:0]);
        32'h4: send_pn_stream(vec[4*i+1], vec[4*i+2][1:0]);
        32'h5: pulse_dovf();
        default: begin
          $display("Unknown opcode %h in operation %0d of the vector file", vec[4*i], i);
          end_failed();
        end
      endcase
    end
    wait_idle(4);
    if (due_q.size() != 0) begin
      $display("Some lane beats never reached their output check");
      end_failed();
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// ==== tb/tpl_adc_vectors.txt ====
// op arg data aux; 0 idle cycles, 1 write addr data, 2 read addr expected, 5 overflow pulse
// 3 lane-beat expected-adc_data expected-adc_valid, 4 pn-beats corrupt-mask, f ends the list
0 00000004 00000000 0
2 00000000 00010061 0
2 00000001 000000a2 0
2 00000008 04010102 0
2 00000009 0000100e 0
2 00000010 00000007 0
2 00000014 00000007 0
2 00000003 00000003 0
1 00000002 5aa5c33c 0
2 00000002 5aa5c33c 0
3 bc1a4523 1abce345 3
1 00000010 0000000f 0
1 00000014 0000000f 0
3 ff1f0020 ffff0000 3
1 00000010 0000000b 0
1 00000014 0000000b 0
3 2301bc3a 21231abc 3
1 00000010 00000001 0
1 00000014 00000001 0
3 0180dec0 8001c0de 3
1 00000010 00000007 0
1 00000014 00000006 0
3 78563412 00001234 1
1 00000014 00000017 0
4 0000000c 00000000 0
0 00000003 00000000 0
2 00000011 00000000 0
2 00000015 00000000 0
2 00000003 00000001 0
4 00000001 00000001 0
4 00000004 00000000 0
0 00000003 00000000 0
2 00000011 00000001 0
2 00000003 00000005 0
1 00000011 00000001 0
2 00000011 00000000 0
4 00000008 00000001 0
0 00000003 00000000 0
2 00000011 00000003 0
2 00000015 00000000 0
2 00000003 00000007 0
5 00000000 00000000 0
2 00000004 00000001 0
1 00000004 00000001 0
2 00000004 00000000 0
2 00000040 00000000 0
f 00000000 00000000 0

// ==== list.f ====
+incdir+src
src/tpl_adc_pkg.sv
src/tpl_adc_deframer.sv
src/tpl_adc_pn_monitor.sv
src/tpl_adc_data_format.sv
src/tpl_adc_regmap.sv
src/tpl_adc_core.sv
tb/tb_tpl_adc.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f list.f --top-module tb_tpl_adc -o sim_tpl_adc
	./obj_dir/sim_tpl_adc

clean:
	rm -rf obj_dir
